/* common/pad_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Pad counts, pad attribute encoding and GPIO register map, shared by
// the register block, the pad cells and the top level
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package pad_pkg;

  // Pad counts
  localparam int unsigned NumMioPads = 8;
  localparam int unsigned NumDioPads = 4;
  localparam int unsigned NumIos     = NumMioPads + NumDioPads; // DIOs sit at 8..11

  // Attribute word layout
  localparam int unsigned AttrDw        = 4;
  localparam int unsigned AttrInvert    = 0; // Inverts both directions
  localparam int unsigned AttrOpenDrain = 1; // Drive low only
  localparam int unsigned AttrPullEn    = 2;
  localparam int unsigned AttrPullUp    = 3; // Clear selects pull-down

  //////////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned RegDw = 16;
  localparam int unsigned RegAw = 5;

  localparam int unsigned AddrOut      = 0;
  localparam int unsigned AddrOe       = 1;
  localparam int unsigned AddrIn       = 2;  // Read only
  localparam int unsigned AddrRise     = 3;  // Write 1 to clear
  localparam int unsigned AddrAttrBase = 16; // One word per pad

  // One bit per pad
  typedef logic [NumIos-1:0] pad_vec_t;

  // One attribute word per pad
  typedef logic [NumIos-1:0][AttrDw-1:0] pad_attr_arr_t;

endpackage : pad_pkg

`default_nettype wire

/* common/jtag_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Pad assignment and strap setup of the JTAG overlay
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package jtag_pkg;
  import pad_pkg::*;

  // Strap and reset live on muxed pads
  localparam int unsigned JtagEnIdx = 7;
  localparam int unsigned TrstIdx   = 6;

  // Serial pins use the dedicated pads
  localparam int unsigned TckIdx = 8;
  localparam int unsigned TmsIdx = 9;
  localparam int unsigned TdiIdx = 10;
  localparam int unsigned TdoIdx = 11;

  // Strap level that turns the overlay on
  localparam logic JtagEnPolarity = 1'b1;

  // Values the core sees on overlay pads while JTAG owns them.
  // The TMS pad doubles as an active-low select, so it idles high.
  localparam pad_vec_t TieOffValues = pad_vec_t'(1) << TmsIdx;

endpackage : jtag_pkg

`default_nettype wire

/* common/pad_if.sv */
////////////////////////////////////////////////////////////////////////////
// Per-pad value, enable, input and attribute bundle between the core,
// the JTAG overlay and the pad ring
////////////////////////////////////////////////////////////////////////////
`default_nettype none

interface pad_if
  import pad_pkg::*;
();

  pad_vec_t      out;
  pad_vec_t      oe;
  pad_vec_t      in;
  pad_attr_arr_t attr;

  // Side that owns the pads
  modport ctrl (
    output out,
    output oe,
    output attr,
    input  in
  );

  // Side that serves the pads
  modport ring (
    input  out,
    input  oe,
    input  attr,
    output in
  );

endinterface : pad_if

`default_nettype wire

/* hdl/gpio_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// GPIO register block with output, enable and attribute registers, an
// input synchronizer and a sticky rising-edge interrupt on a strobe port
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module gpio_ctrl
  import pad_pkg::*;
(
  input  logic             clk_main_i,
  input  logic             reset_i,
  input  logic             reg_we_i,
  input  logic [RegAw-1:0] reg_addr_i,
  input  logic [RegDw-1:0] reg_wdata_i,
  output logic [RegDw-1:0] reg_rdata_o,
  output logic             intr_o,
  pad_if.ctrl              core
);

  pad_vec_t      out_q;
  pad_vec_t      oe_q;
  pad_attr_arr_t attr_q;
  pad_vec_t      in_meta_q;
  pad_vec_t      in_sync_q;
  pad_vec_t      in_prev_q;
  pad_vec_t      rise_q;
  pad_vec_t      rise_set;
  pad_vec_t      rise_clr;
  logic          attr_sel;
  logic [RegAw-1:0]          attr_off;
  logic [$clog2(NumIos)-1:0] attr_idx;

  // Attribute window at AddrAttrBase with one word per pad
  assign attr_sel = (reg_addr_i >= RegAw'(AddrAttrBase)) &&
                    (reg_addr_i < RegAw'(AddrAttrBase + NumIos));
  assign attr_off = reg_addr_i - RegAw'(AddrAttrBase);
  assign attr_idx = attr_off[$clog2(NumIos)-1:0]; // Offset stays below NumIos in the window

  //////////////////////////////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      out_q  <= '0;
      oe_q   <= '0;
      attr_q <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        RegAw'(AddrOut): out_q <= reg_wdata_i[NumIos-1:0];
        RegAw'(AddrOe):  oe_q  <= reg_wdata_i[NumIos-1:0];
        default: begin
          if (attr_sel) begin
            attr_q[attr_idx] <= reg_wdata_i[AttrDw-1:0];
          end
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Input sampling and edge capture
  //////////////////////////////////////////////////////////////////////////

  assign rise_set = in_sync_q & ~in_prev_q;
  assign rise_clr = (reg_we_i && (reg_addr_i == RegAw'(AddrRise))) ?
                    reg_wdata_i[NumIos-1:0] : '0;

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
      rise_q    <= '0;
    end else begin
      in_meta_q <= core.in;    // First stage may go metastable
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
      // A new edge wins over a clear in the same cycle
      rise_q    <= (rise_q & ~rise_clr) | rise_set;
    end
  end

  assign intr_o = |rise_q;

  // Read mux
  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      RegAw'(AddrOut):  reg_rdata_o = RegDw'(out_q);
      RegAw'(AddrOe):   reg_rdata_o = RegDw'(oe_q);
      RegAw'(AddrIn):   reg_rdata_o = RegDw'(in_sync_q);
      RegAw'(AddrRise): reg_rdata_o = RegDw'(rise_q);
      default: begin
        if (attr_sel) begin
          reg_rdata_o = RegDw'(attr_q[attr_idx]);
        end
      end
    endcase
  end

  // Toward the pads
  assign core.out  = out_q;
  assign core.oe   = oe_q;
  assign core.attr = attr_q;

endmodule : gpio_ctrl

`default_nettype wire

/* hdl/jtag_overlay_mux.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG overlay between core and pad ring. The strap pad hands the JTAG
// pads to the TAP ports and the core sees fixed tie-off values instead.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module jtag_overlay_mux
  import jtag_pkg::*;
(
  pad_if.ring  core,
  pad_if.ctrl  ring,
  output logic jtag_tck_o,
  output logic jtag_tms_o,
  output logic jtag_tdi_o,
  output logic jtag_trst_n_o,
  input  logic jtag_tdo_i
);

  logic jtag_en;

  // Strap is read straight off the raw pad input
  assign jtag_en = (ring.in[JtagEnIdx] == JtagEnPolarity);

  // TAP outputs park in reset when the overlay is off
  assign jtag_tck_o    = jtag_en ? ring.in[TckIdx]  : 1'b0;
  assign jtag_tms_o    = jtag_en ? ring.in[TmsIdx]  : 1'b1;
  assign jtag_tdi_o    = jtag_en ? ring.in[TdiIdx]  : 1'b0;
  assign jtag_trst_n_o = jtag_en ? ring.in[TrstIdx] : 1'b0;

  always_comb begin
    ring.out = core.out;
    ring.oe  = core.oe;
    core.in  = ring.in;
    if (jtag_en) begin
      // TDO is the only pad the TAP drives
      ring.out[TdoIdx] = jtag_tdo_i;
      ring.oe[TdoIdx]  = 1'b1;
      ring.oe[TckIdx]  = 1'b0;
      ring.oe[TmsIdx]  = 1'b0;
      ring.oe[TdiIdx]  = 1'b0;
      // Hide the overlay pads from the core
      core.in[TrstIdx] = TieOffValues[TrstIdx];
      core.in[TckIdx]  = TieOffValues[TckIdx];
      core.in[TmsIdx]  = TieOffValues[TmsIdx];
      core.in[TdiIdx]  = TieOffValues[TdiIdx];
      core.in[TdoIdx]  = TieOffValues[TdoIdx];
    end
  end

  assign ring.attr = core.attr; // Attributes never overlaid

endmodule : jtag_overlay_mux

`default_nettype wire

/* padring/pad_cell.sv */
////////////////////////////////////////////////////////////////////////////
// Single pad with inversion, open-drain conversion, a registered output
// stage and input resolution against the board drive and the pull
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module pad_cell
  import pad_pkg::*;
(
  input  logic              clk_main_i,
  input  logic              reset_i,
  input  logic              out_i,
  input  logic              oe_i,
  input  logic [AttrDw-1:0] attr_i,
  input  logic              pad_in_i,
  input  logic              pad_drive_i,
  output logic              in_o,
  output logic              pad_out_o,
  output logic              pad_oe_o
);

  logic out_inv;
  logic out_d;
  logic oe_d;
  logic out_q;
  logic oe_q;
  logic in_raw;

  assign out_inv = out_i ^ attr_i[AttrInvert];

  // Open drain only ever pulls low
  always_comb begin
    if (attr_i[AttrOpenDrain]) begin
      out_d = 1'b0;
      oe_d  = oe_i & ~out_inv;
    end else begin
      out_d = out_inv;
      oe_d  = oe_i;
    end
  end

  always_ff @(posedge clk_main_i) begin
    if (reset_i) begin
      out_q <= 1'b0;
      oe_q  <= 1'b0;
    end else begin
      out_q <= out_d;
      oe_q  <= oe_d;
    end
  end

  // Own driver first, then the board, then the pull
  always_comb begin
    if (oe_q) begin
      in_raw = out_q;
    end else if (pad_drive_i) begin
      in_raw = pad_in_i;
    end else if (attr_i[AttrPullEn]) begin
      in_raw = attr_i[AttrPullUp];
    end else begin
      in_raw = 1'b0; // Floating pad reads low
    end
  end

  assign in_o      = in_raw ^ attr_i[AttrInvert];
  assign pad_out_o = out_q;
  assign pad_oe_o  = oe_q;

endmodule : pad_cell

`default_nettype wire

/* padring/padring.sv */
////////////////////////////////////////////////////////////////////////////
// Pad ring with one pad cell per IO between the ring-side bundle and pins
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module padring
  import pad_pkg::*;
(
  input  logic     clk_main_i,
  input  logic     reset_i,
  pad_if.ring      core,
  input  pad_vec_t pad_in_i,
  input  pad_vec_t pad_drive_i,
  output pad_vec_t pad_out_o,
  output pad_vec_t pad_oe_o
);

  pad_vec_t cell_in;

  for (genvar i = 0; i < NumIos; i++) begin : g_pad
    pad_cell u_pad_cell (
      .clk_main_i  (clk_main_i),
      .reset_i     (reset_i),
      .out_i       (core.out[i]),
      .oe_i        (core.oe[i]),
      .attr_i      (core.attr[i]),
      .pad_in_i    (pad_in_i[i]),
      .pad_drive_i (pad_drive_i[i]),
      .in_o        (cell_in[i]),
      .pad_out_o   (pad_out_o[i]),
      .pad_oe_o    (pad_oe_o[i])
    );
  end

  assign core.in = cell_in;

endmodule : padring

`default_nettype wire

/* hdl/fpga_pad_top.sv */
////////////////////////////////////////////////////////////////////////////
// Board target pin wrapper around GPIO registers, JTAG overlay and pad ring.
// The board is modelled outside through pad_in_i and pad_drive_i.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module fpga_pad_top
  import pad_pkg::*;
(
  input  logic             clk_main_i,
  input  logic             reset_i,
  // Register port
  input  logic             reg_we_i,
  input  logic [RegAw-1:0] reg_addr_i,
  input  logic [RegDw-1:0] reg_wdata_i,
  output logic [RegDw-1:0] reg_rdata_o,
  output logic             intr_o,
  // Pads
  input  pad_vec_t         pad_in_i,
  input  pad_vec_t         pad_drive_i,
  output pad_vec_t         pad_out_o,
  output pad_vec_t         pad_oe_o,
  // JTAG
  output logic             jtag_tck_o,
  output logic             jtag_tms_o,
  output logic             jtag_tdi_o,
  output logic             jtag_trst_n_o,
  input  logic             jtag_tdo_i
);

  pad_if core_bus ();
  pad_if ring_bus ();

  gpio_ctrl u_gpio_ctrl (
    .clk_main_i  (clk_main_i),
    .reset_i     (reset_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .intr_o      (intr_o),
    .core        (core_bus)
  );

  //////////////////////////////////////////////////////////////////////////
  // JTAG overlay and pads
  //////////////////////////////////////////////////////////////////////////

  jtag_overlay_mux u_jtag_overlay_mux (
    .core          (core_bus),
    .ring          (ring_bus),
    .jtag_tck_o    (jtag_tck_o),
    .jtag_tms_o    (jtag_tms_o),
    .jtag_tdi_o    (jtag_tdi_o),
    .jtag_trst_n_o (jtag_trst_n_o),
    .jtag_tdo_i    (jtag_tdo_i)
  );

  padring u_padring (
    .clk_main_i  (clk_main_i),
    .reset_i     (reset_i),
    .core        (ring_bus),
    .pad_in_i    (pad_in_i),
    .pad_drive_i (pad_drive_i),
    .pad_out_o   (pad_out_o),
    .pad_oe_o    (pad_oe_o)
  );

endmodule : fpga_pad_top

`default_nettype wire

/* tb/tb_fpga_pad_top.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the pad wrapper. A board model drives the pads
// through pad_in_i and pad_drive_i; compile it with the RTL file list.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_fpga_pad_top
  import pad_pkg::*;
  import jtag_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ResetCycles   = 3;
  // Rough length of the directed tests in cycles
  localparam int unsigned TestCycles    = 20 + 50 + NumIos * 50 + 80 + 60;
  localparam int unsigned TimeoutCycles = 2 * (ResetCycles + TestCycles);

  localparam pad_vec_t StrapMask   = pad_vec_t'(1) << JtagEnIdx;
  localparam pad_vec_t AllPads     = '1;
  localparam pad_vec_t OverlayMask = 12'hF40; // Pads 6 and 8..11
  localparam pad_vec_t TmsIdleHigh = 12'h200; // Only TMS reads high

  logic             clk_main;
  logic             reset;
  logic             reg_we;
  logic [RegAw-1:0] reg_addr;
  logic [RegDw-1:0] reg_wdata;
  logic [RegDw-1:0] reg_rdata;
  logic             intr;
  pad_vec_t         pad_in;
  pad_vec_t         pad_drive;
  pad_vec_t         pad_out;
  pad_vec_t         pad_oe;
  logic             jtag_tck;
  logic             jtag_tms;
  logic             jtag_tdi;
  logic             jtag_trst_n;
  logic             jtag_tdo;
  logic [31:0]      lfsr_q;
  int unsigned      cycle_count = 0;
  int unsigned      check_count = 0;
  int unsigned      error_count = 0;

  fpga_pad_top DUT (
    .clk_main_i    (clk_main),
    .reset_i       (reset),
    .reg_we_i      (reg_we),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .intr_o        (intr),
    .pad_in_i      (pad_in),
    .pad_drive_i   (pad_drive),
    .pad_out_o     (pad_out),
    .pad_oe_o      (pad_oe),
    .jtag_tck_o    (jtag_tck),
    .jtag_tms_o    (jtag_tms),
    .jtag_tdi_o    (jtag_tdi),
    .jtag_trst_n_o (jtag_trst_n),
    .jtag_tdo_i    (jtag_tdo)
  );

  always #5 clk_main = ~clk_main;

  always @(posedge clk_main) begin
    cycle_count++;
    if (cycle_count > TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] t=%0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] bit_of(input pad_vec_t v, input int unsigned p);
    return {31'b0, |(v & (pad_vec_t'(1) << p))};
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int unsigned n, output logic [15:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[14:0], lfsr_q[0]};
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk_main);
  endtask

  task automatic drive_board(input pad_vec_t value, input pad_vec_t drive);
    @(negedge clk_main);
    pad_in    = value;
    pad_drive = drive;
  endtask

  task automatic reg_write(input int unsigned addr, input logic [RegDw-1:0] data);
    @(negedge clk_main);
    reg_we    = 1'b1;
    reg_addr  = RegAw'(addr);
    reg_wdata = data;
    @(negedge clk_main);
    reg_we    = 1'b0;
  endtask

  task automatic reg_read(input int unsigned addr, output logic [RegDw-1:0] data);
    @(negedge clk_main);
    reg_addr = RegAw'(addr);
    #1;
    data = reg_rdata; // Read data is combinational
  endtask

  task automatic reg_read_check(input int unsigned addr, input logic [RegDw-1:0] exp,
                                input string what);
    logic [RegDw-1:0] data;
    reg_read(addr, data);
    check_value(32'(data), 32'(exp), what);
  endtask

  task automatic jtag_idle_check();
    check_value(32'(jtag_tck), 0, "jtag_tck_o parked");
    check_value(32'(jtag_tms), 1, "jtag_tms_o parked");
    check_value(32'(jtag_tdi), 0, "jtag_tdi_o parked");
    check_value(32'(jtag_trst_n), 0, "jtag_trst_n_o held in reset");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    check_value(32'(pad_out), 0, "pad_out_o after reset");
    check_value(32'(pad_oe), 0, "pad_oe_o after reset");
    check_value(32'(intr), 0, "intr_o after reset");
    jtag_idle_check();
    for (int a = 0; a < 4; a++) begin
      reg_read_check(a, '0, $sformatf("register %0d after reset", a));
    end
    for (int p = 0; p < NumIos; p++) begin
      reg_read_check(AddrAttrBase + p, '0, $sformatf("attribute %0d after reset", p));
    end
  endtask

  task automatic output_path_test();
    logic [15:0] r;
    pad_vec_t    out_v;
    pad_vec_t    oe_v;
    for (int i = 0; i < 4; i++) begin
      random_bits(NumIos, r);
      out_v = pad_vec_t'(r);
      random_bits(NumIos, r);
      oe_v = pad_vec_t'(r) & ~StrapMask; // Own drive on the strap starts JTAG
      reg_write(AddrOut, RegDw'(out_v));
      reg_write(AddrOe, RegDw'(oe_v));
      wait_cycles(1);
      check_value(32'(pad_out), 32'(out_v), "pad_out_o after write");
      check_value(32'(pad_oe), 32'(oe_v), "pad_oe_o after write");
      wait_cycles(3);
      reg_read_check(AddrIn, RegDw'(out_v & oe_v), "loopback into AddrIn");
      reg_read_check(AddrOut, RegDw'(out_v), "AddrOut readback");
      reg_read_check(AddrOe, RegDw'(oe_v), "AddrOe readback");
    end
    reg_write(AddrOe, '0);
    reg_write(AddrOut, '0);
  endtask

  task automatic attribute_test();
    logic [RegDw-1:0] rd;
    pad_vec_t         m;
    int unsigned      attr_addr;
    for (int unsigned p = 0; p < NumIos; p++) begin
      m         = pad_vec_t'(1) << p;
      attr_addr = AddrAttrBase + p;
      // Open drain
      reg_write(attr_addr, RegDw'(1 << AttrOpenDrain));
      reg_write(AddrOut, RegDw'(m));
      reg_write(AddrOe, RegDw'(m));
      wait_cycles(1);
      check_value(bit_of(pad_oe, p), 0, $sformatf("pad %0d open-drain release", p));
      reg_write(AddrOut, '0);
      wait_cycles(1);
      check_value(bit_of(pad_oe, p), 1, $sformatf("pad %0d open-drain low enable", p));
      check_value(bit_of(pad_out, p), 0, $sformatf("pad %0d open-drain low value", p));
      // Inverted core drive
      reg_write(attr_addr, RegDw'(1 << AttrInvert));
      reg_write(AddrOut, RegDw'(m));
      wait_cycles(1);
      check_value(bit_of(pad_out, p), 0, $sformatf("pad %0d inverted drive", p));
      wait_cycles(3);
      reg_read(AddrIn, rd);
      check_value(bit_of(pad_vec_t'(rd), p), 1, $sformatf("pad %0d inverted loopback", p));
      // Inverted board drive
      reg_write(AddrOe, '0);
      drive_board(m, m);
      wait_cycles(4);
      reg_read(AddrIn, rd);
      check_value(bit_of(pad_vec_t'(rd), p), 0, $sformatf("pad %0d inverted input", p));
      // Pulls with the board released
      drive_board('0, '0);
      reg_write(attr_addr, RegDw'((1 << AttrPullEn) | (1 << AttrPullUp)));
      reg_read_check(attr_addr, RegDw'((1 << AttrPullEn) | (1 << AttrPullUp)),
                     $sformatf("pad %0d attribute readback", p));
      wait_cycles(4);
      reg_read(AddrIn, rd);
      check_value(bit_of(pad_vec_t'(rd), p), 1, $sformatf("pad %0d pull-up", p));
      reg_write(attr_addr, RegDw'(1 << AttrPullEn));
      wait_cycles(4);
      reg_read(AddrIn, rd);
      check_value(bit_of(pad_vec_t'(rd), p), 0, $sformatf("pad %0d pull-down", p));
      reg_write(attr_addr, '0);
    end
  endtask

  task automatic input_irq_test();
    logic [15:0] r;
    pad_vec_t    v;
    pad_vec_t    prev;
    pad_vec_t    exp_rise;
    pad_vec_t    clr;
    drive_board('0, AllPads);
    wait_cycles(4);
    reg_write(AddrRise, RegDw'(AllPads));
    reg_read_check(AddrRise, '0, "AddrRise after initial clear");
    check_value(32'(intr), 0, "intr_o after initial clear");
    prev     = '0;
    exp_rise = '0;
    for (int i = 0; i < 8; i++) begin
      random_bits(NumIos, r);
      v = pad_vec_t'(r) & ~StrapMask; // Strap stays low
      drive_board(v, AllPads);
      wait_cycles(4);
      exp_rise = exp_rise | (v & ~prev);
      reg_read_check(AddrIn, RegDw'(v), "AddrIn from board");
      reg_read_check(AddrRise, RegDw'(exp_rise), "AddrRise after input change");
      check_value(32'(intr), 32'(|exp_rise), "intr_o with rising edges");
      prev = v;
    end
    // Low byte first, then the rest
    clr = exp_rise & 12'h0FF;
    reg_write(AddrRise, RegDw'(clr));
    exp_rise = exp_rise & ~clr;
    reg_read_check(AddrRise, RegDw'(exp_rise), "AddrRise after partial clear");
    check_value(32'(intr), 32'(|exp_rise), "intr_o after partial clear");
    reg_write(AddrRise, RegDw'(exp_rise));
    reg_read_check(AddrRise, '0, "AddrRise after full clear");
    check_value(32'(intr), 0, "intr_o after full clear");
  endtask

  task automatic jtag_overlay_test();
    logic [15:0]      r;
    logic [RegDw-1:0] rd;
    pad_vec_t         v;
    drive_board('0, AllPads);
    jtag_tdo = 1'b0;
    reg_write(AddrOut, 16'h0A00);
    reg_write(AddrOe, 16'h0F00);
    wait_cycles(1);
    check_value(32'(pad_out), 32'h0A00, "pad_out_o with JTAG off");
    check_value(32'(pad_oe), 32'h0F00, "pad_oe_o with JTAG off");
    jtag_idle_check();
    drive_board(StrapMask, AllPads);
    wait_cycles(1); // Lets the TCK, TMS and TDI pads release
    for (int i = 0; i < 6; i++) begin
      random_bits(5, r);
      v = StrapMask | (pad_vec_t'(r[2:0]) << TckIdx) | (pad_vec_t'(r[3]) << TrstIdx);
      drive_board(v, AllPads);
      jtag_tdo = r[4];
      #1;
      check_value(32'(jtag_tck), 32'(r[0]), "jtag_tck_o follows pad 8");
      check_value(32'(jtag_tms), 32'(r[1]), "jtag_tms_o follows pad 9");
      check_value(32'(jtag_tdi), 32'(r[2]), "jtag_tdi_o follows pad 10");
      check_value(32'(jtag_trst_n), 32'(r[3]), "jtag_trst_n_o follows pad 6");
      wait_cycles(1);
      check_value(bit_of(pad_out, TdoIdx), 32'(r[4]), "TDO pad after jtag_tdo_i");
      check_value(32'(pad_oe), 32'h0800, "pad_oe_o with JTAG on");
    end
    // Raw levels opposite to the tie-off on every overlay pad
    drive_board(StrapMask | (OverlayMask & ~TmsIdleHigh), AllPads);
    jtag_tdo = 1'b1;
    wait_cycles(3);
    reg_read(AddrIn, rd);
    check_value(32'(pad_vec_t'(rd) & OverlayMask), 32'(TmsIdleHigh), "AddrIn tie-off");
    // Core writes must not reach the overlay pads
    reg_write(AddrOut, 16'h0500);
    reg_write(AddrOe, '0);
    wait_cycles(1);
    check_value(32'(pad_out), 32'(12'h500 | (pad_vec_t'(jtag_tdo) << TdoIdx)),
                "pad_out_o under JTAG after core write");
    check_value(32'(pad_oe), 32'h0800, "pad_oe_o under JTAG after core write");
    drive_board(12'h700, AllPads);
    #1;
    jtag_idle_check();
    wait_cycles(1);
    check_value(32'(pad_out), 32'h0500, "pad_out_o after JTAG off");
    check_value(32'(pad_oe), 0, "pad_oe_o after JTAG off");
    wait_cycles(3);
    reg_read_check(AddrIn, 16'h0700, "AddrIn pass-through after JTAG off");
  endtask

  initial begin
    clk_main  = 1'b0;
    reset     = 1'b1;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    pad_in    = '0;
    pad_drive = '0;
    jtag_tdo  = 1'b0;
    lfsr_q    = 32'd81798;
    repeat (ResetCycles) @(posedge clk_main);
    @(negedge clk_main);
    reset = 1'b0;
    reset_state_test();
    output_path_test();
    attribute_test();
    input_irq_test();
    jtag_overlay_test();
    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_fpga_pad_top

`default_nettype wire

/* verilog.f */
common/pad_pkg.sv
common/jtag_pkg.sv
common/pad_if.sv
hdl/gpio_ctrl.sv
hdl/jtag_overlay_mux.sv
padring/pad_cell.sv
padring/padring.sv
hdl/fpga_pad_top.sv
tb/tb_fpga_pad_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the pad wrapper testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_fpga_pad_top \
  -f verilog.f \
  -o tb_sim

./obj_dir/tb_sim | tee "$LOG"

if grep -q "Simulation finished: PASS" "$LOG"; then
  echo "Test run passed"
else
  echo "Test run failed, see $LOG"
  exit 1
fi
